/* processor_patterns.txt */
# columns: tag, hex value. P = program word in address order, I = input-port value,
# E = expected output value in the order the core sends them
I 5A3C # input port
P 9200 # 0  in   r1
P 2048 # 1  sub  r0, r1, r1      r0 = 0
P 6407 # 2  addi r2, r0, 7
P 663F # 3  addi r3, r0, -1      r3 = ffff
P 18D0 # 4  add  r4, r3, r2      wraps to 0006
P A100 # 5  out  r4
P 5B08 # 6  xor  r5, r4, r1      5a3a
P 3D48 # 7  and  r6, r5, r1      5a38
P 4D90 # 8  or   r6, r6, r2      5a3f
P A180 # 9  out  r6
P 2AB0 # 10 sub  r5, r2, r6      a5c8
P A140 # 11 out  r5
P 8A83 # 12 st   r5, 3(r2)       mem[10] = a5c8
P 760A # 13 ld   r3, 10(r0)
P 66C1 # 14 addi r3, r3, 1       load-use, a5c9
P A0C0 # 15 out  r3
P B001 # 16 beqz r0, +1          taken
P A040 # 17 out  r1              skipped
P B081 # 18 beqz r2, +1          not taken
P A080 # 19 out  r2
P C002 # 20 jmp  +2
P A040 # 21 out  r1              skipped
P A040 # 22 out  r1              skipped
P 9E00 # 23 in   r7
P 0000 # 24 nop
P 0000 # 25 nop
P A1C0 # 26 out  r7              read in the writeback cycle
P C03F # 27 jmp  -1              halt loop
P 0000 # 28 nop
P 0000 # 29 nop
E 0006
E 5A3F
E A5C8
E A5C9
E 0007
E 5A3C

/* flist.f */
procPkg.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
processor.sv
processor_sva.sv
tb_processor.sv

/* Bender.yml */
package:
  name: processor

sources:
  - procPkg.sv
  - fetchStage.sv
  - decodeStage.sv
  - hazardUnit.sv
  - executeStage.sv
  - memoryStage.sv
  - processor.sv
  - target: test
    files:
      - processor_sva.sv
      - tb_processor.sv

/* tb_processor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_processor import procPkg::*; ();

    localparam int imemAddrW = 6;
    localparam int dmemAddrW = 6;
    localparam int clkPeriod = 4;
    localparam int driveDelay = 1;
    localparam int resetCycles = 3;
    // watchdog budget per pattern line
    localparam int cyclesPerPattern = 50;
    // quiet window after the last expected output
    localparam int drainCycles = 20;

    logic clk;
    logic rstN;
    logic start;
    logic imemWe;
    logic [imemAddrW-1:0] imemAddr;
    logic [dataW-1:0] imemData;
    logic [dataW-1:0] inputPort;
    logic [dataW-1:0] outputPort;
    logic outValid;

    // pattern file contents
    logic [dataW-1:0] progWords[$];
    logic [dataW-1:0] expectOut[$];
    logic [dataW-1:0] inputValue;
    int patternLines;
    bit patternsLoaded;

    // monitor state
    bit started;
    int outIdx;

    processor #(
        .imemAddrW(imemAddrW),
        .dmemAddrW(dmemAddrW)
    ) processor_inst (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .inputPort(inputPort),
        .outputPort(outputPort),
        .outValid(outValid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    task automatic abortRun();
        $display("TB FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkValue(
        input string            what,
        input logic [dataW-1:0] actual,
        input logic [dataW-1:0] expected
    );
        if (actual !== expected) begin
            $display("** Error @ %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            abortRun();
        end
    endtask

    // P program word, I input-port value, E expected output
    task automatic readPatterns();
        int fd;
        int got;
        string line;
        byte tag;
        logic [dataW-1:0] value;
        fd = $fopen("processor_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open processor_patterns.txt");
            abortRun();
        end else begin
            while ($fgets(line, fd) > 0) begin
                got = $sscanf(line, "%c %h", tag, value);
                // comment and blank lines fall through
                if (got == 2 && tag == "P") begin
                    progWords.push_back(value);
                    patternLines++;
                end else if (got == 2 && tag == "I") begin
                    inputValue = value;
                    patternLines++;
                end else if (got == 2 && tag == "E") begin
                    expectOut.push_back(value);
                    patternLines++;
                end
            end
            $fclose(fd);
        end
    endtask

    // one word per cycle through the loader port
    task automatic loadProgram();
        foreach (progWords[i]) begin
            @(posedge clk);
            #driveDelay;
            imemWe = 1'b1;
            imemAddr = imemAddrW'(i);
            imemData = progWords[i];
        end
        @(posedge clk);
        #driveDelay;
        imemWe = 1'b0;
    endtask

    task automatic pulseStart();
        @(posedge clk);
        #driveDelay;
        inputPort = inputValue;
        start = 1'b1;
        started = 1'b1;
        @(posedge clk);
        #driveDelay;
        start = 1'b0;
    endtask

    // outValid and outputPort are sampled one edge after they were registered
    always @(posedge clk) begin
        if (rstN === 1'b1 && outValid !== 1'b0) begin
            if (!started) begin
                $display("output strobe seen before the core was started");
                abortRun();
            end else if (outIdx >= expectOut.size()) begin
                $display("output strobe seen after the last expected value");
                abortRun();
            end else begin
                checkValue($sformatf("output %0d", outIdx), outputPort, expectOut[outIdx]);
                outIdx++;
            end
        end
    end

    // watchdog, scaled by the pattern count
    initial begin
        wait (patternsLoaded);
        repeat (patternLines * cyclesPerPattern) @(posedge clk);
        $display("timeout: the program did not finish within %0d cycles",
                 patternLines * cyclesPerPattern);
        abortRun();
    end

    initial begin
        rstN = 1'b0;
        start = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        inputPort = '0;
        started = 1'b0;
        outIdx = 0;
        patternLines = 0;
        patternsLoaded = 1'b0;
        readPatterns();
        if (progWords.size() == 0 || progWords.size() > 2**imemAddrW
                || expectOut.size() == 0) begin
            $display("pattern file holds no usable program or no expected outputs");
            abortRun();
        end
        patternsLoaded = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        rstN = 1'b1;
        loadProgram();
        // idle gap, the monitor flags any strobe here
        repeat (4) @(posedge clk);
        pulseStart();
        wait (outIdx == expectOut.size());
        repeat (drainCycles) @(posedge clk);
        // past the last monitor sample
        #driveDelay;
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* processor_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module processor_sva import procPkg::*; #(
    parameter int imemAddrW = 6
) (
    input logic                 clk,
    input logic                 rstN,
    input runState_e            runState,
    input logic [imemAddrW-1:0] pc,
    input logic                 stall,
    input logic                 flushFd,
    input logic                 flushDe,
    input logic [dataW-1:0]     fdInstr,
    input opcode_e              deOpcode,
    input logic                 outValid
);

    // a reset edge leaves the strobe and hazard lines low
    resetQuiet: assert property (@(posedge clk)
        !rstN |=> !outValid && !stall && !flushFd && !flushDe)
        else $error("strobe or hazard line high after reset");

    // nothing comes out before start
    idleSilent: assert property (@(posedge clk) disable iff (!rstN)
        runState == idle |-> !outValid)
        else $error("outValid high while idle");

    // stalled pc keeps its value
    stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable(pc))
        else $error("pc moved during a stall");

    // both squash lines fire together
    // and leave a bubble in both younger slots
    flushTogether: assert property (@(posedge clk) disable iff (!rstN)
        (flushFd || flushDe) |-> (flushFd && flushDe)
            ##1 (fdInstr == nopInstr && deOpcode == opNop))
        else $error("flushFd and flushDe out of step or slots not squashed");

endmodule

bind processor processor_sva #(
    .imemAddrW(imemAddrW)
) processorSvaInst (
    .clk(clk),
    .rstN(rstN),
    .runState(fetchStageInst.runState),
    .pc(fetchStageInst.pc),
    .stall(stall),
    .flushFd(flushFd),
    .flushDe(flushDe),
    .fdInstr(fdInstr),
    .deOpcode(deOpcode),
    .outValid(outValid)
);

`default_nettype wire

/* processor.sv */
`timescale 1ns/1ps
`default_nettype none

module processor import procPkg::*; #(
    parameter int imemAddrW = 6,
    parameter int dmemAddrW = 6
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  logic                 imemWe,
    input  logic [imemAddrW-1:0] imemAddr,
    input  logic [dataW-1:0]     imemData,
    input  logic [dataW-1:0]     inputPort,
    output logic [dataW-1:0]     outputPort,
    output logic                 outValid
);

    // hazard control
    logic stall;
    logic flushFd;
    logic flushDe;
    logic branchTaken;
    logic [imemAddrW-1:0] branchTarget;

    // fetch/decode register
    logic [dataW-1:0] fdInstr;
    logic [imemAddrW-1:0] fdPc;

    // decode/execute register
    opcode_e deOpcode;
    logic [regAddrW-1:0] deRd;
    logic [regAddrW-1:0] deRs;
    logic [regAddrW-1:0] deRt;
    logic [immW-1:0] deImm;
    logic [dataW-1:0] deRsData;
    logic [dataW-1:0] deRtData;
    logic [imemAddrW-1:0] dePc;
    logic deIsLoad;

    // execute/memory register
    logic [dataW-1:0] emAluResult;
    logic [dataW-1:0] emStoreData;
    logic [regAddrW-1:0] emRd;
    logic emRegWrite;
    logic emMemRead;
    logic emMemWrite;
    logic emIsOut;

    // memory/writeback register, also the regfile write port
    logic [regAddrW-1:0] mwRd;
    logic mwRegWrite;
    logic [dataW-1:0] mwData;

    fetchStage #(
        .imemAddrW(imemAddrW)
    ) fetchStageInst (
        .clk(clk),
        .rstN(rstN),
        .start(start),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .stall(stall),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .flushFd(flushFd),
        .fdInstr(fdInstr),
        .fdPc(fdPc)
    );

    decodeStage #(
        .imemAddrW(imemAddrW)
    ) decodeStageInst (
        .clk(clk),
        .rstN(rstN),
        .fdInstr(fdInstr),
        .fdPc(fdPc),
        .stall(stall),
        .flushDe(flushDe),
        .mwRd(mwRd),
        .mwRegWrite(mwRegWrite),
        .mwData(mwData),
        .deOpcode(deOpcode),
        .deRd(deRd),
        .deRs(deRs),
        .deRt(deRt),
        .deImm(deImm),
        .deRsData(deRsData),
        .deRtData(deRtData),
        .dePc(dePc),
        .deIsLoad(deIsLoad)
    );

    // compares the load in execute against the decode sources
    hazardUnit hazardUnitInst (
        .fdInstr(fdInstr),
        .deIsLoad(deIsLoad),
        .deRd(deRd),
        .branchTaken(branchTaken),
        .stall(stall),
        .flushFd(flushFd),
        .flushDe(flushDe)
    );

    executeStage #(
        .imemAddrW(imemAddrW)
    ) executeStageInst (
        .clk(clk),
        .rstN(rstN),
        .deOpcode(deOpcode),
        .deRd(deRd),
        .deRs(deRs),
        .deRt(deRt),
        .deImm(deImm),
        .deRsData(deRsData),
        .deRtData(deRtData),
        .dePc(dePc),
        .inputPort(inputPort),
        .mwRd(mwRd),
        .mwRegWrite(mwRegWrite),
        .mwData(mwData),
        .branchTaken(branchTaken),
        .branchTarget(branchTarget),
        .emAluResult(emAluResult),
        .emStoreData(emStoreData),
        .emRd(emRd),
        .emRegWrite(emRegWrite),
        .emMemRead(emMemRead),
        .emMemWrite(emMemWrite),
        .emIsOut(emIsOut)
    );

    memoryStage #(
        .dmemAddrW(dmemAddrW)
    ) memoryStageInst (
        .clk(clk),
        .rstN(rstN),
        .emAluResult(emAluResult),
        .emStoreData(emStoreData),
        .emRd(emRd),
        .emRegWrite(emRegWrite),
        .emMemRead(emMemRead),
        .emMemWrite(emMemWrite),
        .emIsOut(emIsOut),
        .mwRd(mwRd),
        .mwRegWrite(mwRegWrite),
        .mwData(mwData),
        .outputPort(outputPort),
        .outValid(outValid)
    );

endmodule

`default_nettype wire

/* memoryStage.sv */
`timescale 1ns/1ps
`default_nettype none

module memoryStage import procPkg::*; #(
    parameter int dmemAddrW = 6
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic [dataW-1:0]    emAluResult,
    input  logic [dataW-1:0]    emStoreData,
    input  logic [regAddrW-1:0] emRd,
    input  logic                emRegWrite,
    input  logic                emMemRead,
    input  logic                emMemWrite,
    input  logic                emIsOut,
    output logic [regAddrW-1:0] mwRd,
    output logic                mwRegWrite,
    output logic [dataW-1:0]    mwData,
    output logic [dataW-1:0]    outputPort,
    output logic                outValid
);

    // data store
    logic [dataW-1:0] dmem [2**dmemAddrW];
    logic [dmemAddrW-1:0] addr;
    logic [dataW-1:0] result;

    // low bits of the alu result address the memory
    assign addr = emAluResult[dmemAddrW-1:0];

    always_ff @(posedge clk) begin
        if (emMemWrite) begin
            dmem[addr] <= emStoreData;
        end
    end

    // writeback select, load data or alu result
    assign result = emMemRead ? dmem[addr] : emAluResult;

    // memory/writeback control and output strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            mwRegWrite <= 1'b0;
            outValid <= 1'b0;
        end else begin
            mwRegWrite <= emRegWrite;
            outValid <= emIsOut;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        mwRd <= emRd;
        mwData <= result;
        // port holds the last value sent
        if (emIsOut) begin
            outputPort <= emAluResult;
        end
    end

endmodule

`default_nettype wire

/* executeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module executeStage import procPkg::*; #(
    parameter int imemAddrW = 6
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  opcode_e              deOpcode,
    input  logic [regAddrW-1:0]  deRd,
    input  logic [regAddrW-1:0]  deRs,
    input  logic [regAddrW-1:0]  deRt,
    input  logic [immW-1:0]      deImm,
    input  logic [dataW-1:0]     deRsData,
    input  logic [dataW-1:0]     deRtData,
    input  logic [imemAddrW-1:0] dePc,
    input  logic [dataW-1:0]     inputPort,
    input  logic [regAddrW-1:0]  mwRd,
    input  logic                 mwRegWrite,
    input  logic [dataW-1:0]     mwData,
    output logic                 branchTaken,
    output logic [imemAddrW-1:0] branchTarget,
    output logic [dataW-1:0]     emAluResult,
    output logic [dataW-1:0]     emStoreData,
    output logic [regAddrW-1:0]  emRd,
    output logic                 emRegWrite,
    output logic                 emMemRead,
    output logic                 emMemWrite,
    output logic                 emIsOut
);

    logic [dataW-1:0] opA;
    logic [dataW-1:0] opB;
    logic [dataW-1:0] immExt;
    logic [dataW-1:0] aluResult;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic isOut;

    // em pair is younger than the writeback pair, so it is checked first
    function automatic logic [dataW-1:0] forward(
        input logic [regAddrW-1:0] idx,
        input logic [dataW-1:0]    regVal
    );
        if (emRegWrite && emRd == idx) begin
            return emAluResult;
        end
        if (mwRegWrite && mwRd == idx) begin
            return mwData;
        end
        return regVal;
    endfunction

    always_comb begin
        opA = forward(deRs, deRsData);
        opB = forward(deRt, deRtData);
    end

    assign immExt = {{(dataW-immW){deImm[immW-1]}}, deImm};

    // alu and per-opcode control
    always_comb begin
        aluResult = '0;
        regWrite = 1'b0;
        memRead = 1'b0;
        memWrite = 1'b0;
        isOut = 1'b0;
        branchTaken = 1'b0;
        case (deOpcode)
            opAdd: begin
                aluResult = opA + opB;
                regWrite = 1'b1;
            end
            opSub: begin
                aluResult = opA - opB;
                regWrite = 1'b1;
            end
            opAnd: begin
                aluResult = opA & opB;
                regWrite = 1'b1;
            end
            opOr: begin
                aluResult = opA | opB;
                regWrite = 1'b1;
            end
            opXor: begin
                aluResult = opA ^ opB;
                regWrite = 1'b1;
            end
            opAddi: begin
                aluResult = opA + immExt;
                regWrite = 1'b1;
            end
            opLd: begin
                // effective address
                aluResult = opA + immExt;
                regWrite = 1'b1;
                memRead = 1'b1;
            end
            opSt: begin
                aluResult = opA + immExt;
                memWrite = 1'b1;
            end
            opIn: begin
                aluResult = inputPort;
                regWrite = 1'b1;
            end
            opOut: begin
                // rs value rides to the output port
                aluResult = opA;
                isOut = 1'b1;
            end
            opBeqz: begin
                branchTaken = (opA == '0);
            end
            opJmp: begin
                branchTaken = 1'b1;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

    // pc-relative, pc+1+imm wrapped to the imem size
    assign branchTarget = dePc + imemAddrW'(1) + immExt[imemAddrW-1:0];

    // execute/memory register, control part
    always_ff @(posedge clk) begin
        if (!rstN) begin
            emRegWrite <= 1'b0;
            emMemRead <= 1'b0;
            emMemWrite <= 1'b0;
            emIsOut <= 1'b0;
        end else begin
            emRegWrite <= regWrite;
            emMemRead <= memRead;
            emMemWrite <= memWrite;
            emIsOut <= isOut;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        emAluResult <= aluResult;
        emStoreData <= opB;
        emRd <= deRd;
    end

endmodule

`default_nettype wire

/* hazardUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit import procPkg::*; (
    input  logic [dataW-1:0]    fdInstr,
    input  logic                deIsLoad,
    input  logic [regAddrW-1:0] deRd,
    input  logic                branchTaken,
    output logic                stall,
    output logic                flushFd,
    output logic                flushDe
);

    opcode_e fdOp;
    logic [regAddrW-1:0] fdRs;
    logic [regAddrW-1:0] fdSrcB;
    logic readsRs;
    logic readsB;
    logic loadUse;

    assign fdOp = opcode_e'(fdInstr[opcodeLsb +: opcodeW]);
    assign fdRs = fdInstr[rsLsb +: regAddrW];
    assign fdSrcB = secondSrc(fdInstr);

    // which sources the decode instruction really reads
    always_comb begin
        readsRs = 1'b0;
        readsB = 1'b0;
        case (fdOp)
            opAdd, opSub, opAnd, opOr, opXor, opSt: begin
                readsRs = 1'b1;
                readsB = 1'b1;
            end
            opAddi, opLd, opOut, opBeqz: begin
                readsRs = 1'b1;
            end
            default: begin
                readsRs = 1'b0;
            end
        endcase
    end

    // load in execute feeding the next instruction
    assign loadUse = deIsLoad && ((readsRs && deRd == fdRs) || (readsB && deRd == fdSrcB));

    // taken branch squashes both younger slots, flush beats stall
    assign flushFd = branchTaken;
    assign flushDe = branchTaken;
    assign stall = loadUse && !branchTaken;

endmodule

`default_nettype wire

/* decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage import procPkg::*; #(
    parameter int imemAddrW = 6
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [dataW-1:0]     fdInstr,
    input  logic [imemAddrW-1:0] fdPc,
    input  logic                 stall,
    input  logic                 flushDe,
    input  logic [regAddrW-1:0]  mwRd,
    input  logic                 mwRegWrite,
    input  logic [dataW-1:0]     mwData,
    output opcode_e              deOpcode,
    output logic [regAddrW-1:0]  deRd,
    output logic [regAddrW-1:0]  deRs,
    output logic [regAddrW-1:0]  deRt,
    output logic [immW-1:0]      deImm,
    output logic [dataW-1:0]     deRsData,
    output logic [dataW-1:0]     deRtData,
    output logic [imemAddrW-1:0] dePc,
    output logic                 deIsLoad
);

    // eight general registers
    logic [dataW-1:0] regFile [2**regAddrW];

    opcode_e opcode;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs;
    // second source, rd for st
    logic [regAddrW-1:0] rt;
    logic [immW-1:0] imm;
    logic [dataW-1:0] rsData;
    logic [dataW-1:0] rtData;
    logic isLoad;

    // field split
    assign opcode = opcode_e'(fdInstr[opcodeLsb +: opcodeW]);
    assign rd = fdInstr[rdLsb +: regAddrW];
    assign rs = fdInstr[rsLsb +: regAddrW];
    assign rt = secondSrc(fdInstr);
    assign imm = fdInstr[immLsb +: immW];

    // unknown words count as non-loads
    always_comb begin
        case (opcode)
            opLd:    isLoad = 1'b1;
            default: isLoad = 1'b0;
        endcase
    end

    // writeback port
    always_ff @(posedge clk) begin
        if (mwRegWrite) begin
            regFile[mwRd] <= mwData;
        end
    end

    // write-through, same-cycle write wins over the array
    assign rsData = (mwRegWrite && mwRd == rs) ? mwData : regFile[rs];
    assign rtData = (mwRegWrite && mwRd == rt) ? mwData : regFile[rt];

    // decode/execute control, bubble on flush or stall
    always_ff @(posedge clk) begin
        if (!rstN) begin
            deOpcode <= opNop;
            deIsLoad <= 1'b0;
        end else if (flushDe || stall) begin
            deOpcode <= opNop;
            deIsLoad <= 1'b0;
        end else begin
            deOpcode <= opcode;
            deIsLoad <= isLoad;
        end
    end

    // payload, harmless under a nop opcode
    always_ff @(posedge clk) begin
        deRd <= rd;
        deRs <= rs;
        deRt <= rt;
        deImm <= imm;
        deRsData <= rsData;
        deRtData <= rtData;
        dePc <= fdPc;
    end

endmodule

`default_nettype wire

/* fetchStage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetchStage import procPkg::*; #(
    parameter int imemAddrW = 6
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 start,
    input  logic                 imemWe,
    input  logic [imemAddrW-1:0] imemAddr,
    input  logic [dataW-1:0]     imemData,
    input  logic                 stall,
    input  logic                 branchTaken,
    input  logic [imemAddrW-1:0] branchTarget,
    input  logic                 flushFd,
    output logic [dataW-1:0]     fdInstr,
    output logic [imemAddrW-1:0] fdPc
);

    // program store
    logic [dataW-1:0] imem [2**imemAddrW];
    logic [imemAddrW-1:0] pc;
    runState_e runState;

    // loader port, only while idle
    always_ff @(posedge clk) begin
        if (imemWe && runState == idle) begin
            imem[imemAddr] <= imemData;
        end
    end

    // run state and pc
    always_ff @(posedge clk) begin
        if (!rstN) begin
            runState <= idle;
            pc <= '0;
        end else if (runState == idle) begin
            // start strobe launches at address 0
            if (start) begin
                runState <= running;
                pc <= '0;
            end
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fdInstr <= nopInstr;
        end else if (runState == idle || flushFd) begin
            // squashed or not yet running
            fdInstr <= nopInstr;
        end else if (!stall) begin
            fdInstr <= imem[pc];
        end
    end

    // pc tag travels with its word
    always_ff @(posedge clk) begin
        if (!stall) begin
            fdPc <= pc;
        end
    end

endmodule

`default_nettype wire

/* procPkg.sv */
`default_nettype none

package procPkg;

    // datapath and field widths
    localparam int dataW = 16;
    localparam int regAddrW = 3;
    localparam int immW = 6;
    localparam int opcodeW = 4;

    // lsb of each instruction field
    localparam int opcodeLsb = 12;
    localparam int rdLsb = 9;
    localparam int rsLsb = 6;
    localparam int rtLsb = 3;
    // signed immediate overlays rt
    localparam int immLsb = 0;

    typedef enum logic [opcodeW-1:0] {
        opNop  = 4'd0,
        opAdd  = 4'd1,
        opSub  = 4'd2,
        opAnd  = 4'd3,
        opOr   = 4'd4,
        opXor  = 4'd5,
        opAddi = 4'd6,
        opLd   = 4'd7,
        opSt   = 4'd8,
        opIn   = 4'd9,
        opOut  = 4'd10,
        opBeqz = 4'd11,
        opJmp  = 4'd12
    } opcode_e;

    typedef enum logic {
        idle    = 1'b0,
        running = 1'b1
    } runState_e;

    // all-zero word decodes as nop
    localparam logic [dataW-1:0] nopInstr = '0;

    // index of the second register read
    // st has no rt, its store data comes from the rd field
    function automatic logic [regAddrW-1:0] secondSrc(input logic [dataW-1:0] instr);
        logic [opcodeW-1:0] op;
        op = instr[opcodeLsb +: opcodeW];
        if (op == opSt) begin
            return instr[rdLsb +: regAddrW];
        end
        return instr[rtLsb +: regAddrW];
    endfunction

endpackage

`default_nettype wire
